// File: filelist.f
+incdir+source
source/iq_data_pkg.sv
source/iq_ctrl_pkg.sv
source/iq_entry.sv
source/iq_alloc.sv
source/iq_select.sv
source/iq_alu.sv
source/issue_queue.sv
tb/issue_queue_chk.sv
tb/tb_issue_queue.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_queue \
    -f filelist.f \
    -o sim_issue_queue

# a fatal stop exits non-zero, the log decides the outcome
./obj_dir/sim_issue_queue +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a pass line"
    exit 1
fi
echo "run ok"

// File: tb/tb_issue_queue.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module tb_issue_queue;

    localparam int NUM_TAGS = 1 << `IQ_TAG_W;
    localparam int TIMEOUT  = 200;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  flush;
    logic                                  disp_valid;
    iq_data_pkg::operand_t [1:0]           disp_src;
    iq_ctrl_pkg::decode_info_t             disp_di;
    iq_data_pkg::cdb_t [`IQ_CDB_PORTS-1:0] cdb;
    logic                                  full;
    iq_data_pkg::result_t                  res;

    // scoreboard indexed by tag, the checker reads it too
    logic [`IQ_DATA_W-1:0] tag_val [NUM_TAGS];
    logic                  outstanding [NUM_TAGS];
    logic                  done [NUM_TAGS];

    integer seed;

    issue_queue u_issue_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush),
        .disp_valid_i (disp_valid),
        .disp_src_i   (disp_src),
        .disp_di_i    (disp_di),
        .full_o       (full),
        .cdb_i        (cdb),
        .res_o        (res)
    );

    bind issue_queue issue_queue_chk u_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .full_i  (full_o),
        .grant_i (grant_oh),
        .res_i   (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [`IQ_DATA_W-1:0] apply_op(
        input iq_ctrl_pkg::alu_op_e  op,
        input logic [`IQ_DATA_W-1:0] a,
        input logic [`IQ_DATA_W-1:0] b
    );
        case (op)
            iq_ctrl_pkg::OP_ADD: return a + b;
            iq_ctrl_pkg::OP_SUB: return a - b;
            iq_ctrl_pkg::OP_AND: return a & b;
            default:             return a ^ b;
        endcase
    endfunction

    // pending operands carry junk in the value field
    function automatic iq_data_pkg::operand_t make_opnd(
        input logic                 rdy,
        input logic [`IQ_TAG_W-1:0] tag
    );
        iq_data_pkg::operand_t o;
        o.ready = rdy;
        o.tag   = tag;
        o.value = $random(seed);
        return o;
    endfunction

    function automatic logic [`IQ_DATA_W-1:0] opnd_value(input iq_data_pkg::operand_t o);
        return o.ready ? o.value : tag_val[o.tag];
    endfunction

    task automatic set_known(input logic [`IQ_TAG_W-1:0] tag);
        tag_val[tag] = $random(seed);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_full(input logic level);
        int cnt;
        cnt = 0;
        while (full != level && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (full != level) begin
            abort_run($sformatf("full flag never reached %0d", level));
        end
    endtask

    task automatic dispatch(
        input iq_ctrl_pkg::alu_op_e  op,
        input iq_data_pkg::operand_t a,
        input iq_data_pkg::operand_t b,
        input logic [`IQ_TAG_W-1:0]  dst
    );
        wait_full(1'b0);
        tag_val[dst]     = apply_op(op, opnd_value(a), opnd_value(b));
        outstanding[dst] = 1'b1;
        disp_valid       = 1'b1;
        disp_src[0]      = a;
        disp_src[1]      = b;
        disp_di.op       = op;
        disp_di.dst_tag  = dst;
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    // one-cycle broadcast of a known tag
    task automatic broadcast(input int port, input logic [`IQ_TAG_W-1:0] tag);
        cdb[port].valid = 1'b1;
        cdb[port].tag   = tag;
        cdb[port].value = tag_val[tag];
        @(posedge clk);
        #1;
        cdb[port].valid = 1'b0;
    endtask

    task automatic wait_done(input logic [`IQ_TAG_W-1:0] tag);
        int cnt;
        cnt = 0;
        while (!done[tag] && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!done[tag]) begin
            abort_run($sformatf("tag %0d never completed within %0d cycles", tag, TIMEOUT));
        end
    endtask

    // dispatch in the flush cycle has to be dropped as well
    task automatic flush_with_dispatch(input logic [`IQ_TAG_W-1:0] dst);
        flush           = 1'b1;
        disp_valid      = 1'b1;
        disp_src[0]     = make_opnd(1'b1, '0);
        disp_src[1]     = make_opnd(1'b1, '0);
        disp_di.op      = iq_ctrl_pkg::OP_ADD;
        disp_di.dst_tag = dst;
        @(posedge clk);
        #1;
        flush      = 1'b0;
        disp_valid = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
        end
    endtask

    // completion tracking
    always @(posedge clk) begin
        if (rst_n && res.valid) begin
            done[res.tag]        <= 1'b1;
            outstanding[res.tag] <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (u_issue_queue.u_chk.err_cnt != 0) begin
            abort_run("a bound assertion on result, full or flush behavior failed");
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        seed       = 32'h9c798167;
        rst_n      = 1'b0;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp_src   = '0;
        disp_di    = '0;
        cdb        = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_val[t]     = '0;
            outstanding[t] = 1'b0;
            done[t]        = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // ready at dispatch, every opcode
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd0);
        dispatch(iq_ctrl_pkg::OP_SUB, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd1);
        dispatch(iq_ctrl_pkg::OP_AND, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd2);
        dispatch(iq_ctrl_pkg::OP_XOR, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd3);
        for (int t = 0; t < 4; t++) begin
            wait_done(5'(t));
        end

        // operands woken by the CDB, later and in the dispatch cycle
        set_known(5'd24);
        set_known(5'd25);
        set_known(5'd26);
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b0, 5'd24), make_opnd(1'b1, '0), 5'd4);
        dispatch(iq_ctrl_pkg::OP_SUB, make_opnd(1'b1, '0), make_opnd(1'b0, 5'd25), 5'd5);
        cdb[1].valid = 1'b1;
        cdb[1].tag   = 5'd26;
        cdb[1].value = tag_val[26];
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b0, 5'd26), make_opnd(1'b1, '0), 5'd6);
        cdb[1].valid = 1'b0;
        broadcast(0, 5'd24);
        broadcast(1, 5'd25);
        for (int t = 4; t < 7; t++) begin
            wait_done(5'(t));
        end

        // dependent chain over the back-to-back wakeup only
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd7);
        dispatch(iq_ctrl_pkg::OP_SUB, make_opnd(1'b0, 5'd7), make_opnd(1'b1, '0), 5'd8);
        dispatch(iq_ctrl_pkg::OP_XOR, make_opnd(1'b1, '0), make_opnd(1'b0, 5'd8), 5'd9);
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b0, 5'd9), make_opnd(1'b1, '0), 5'd10);
        for (int t = 7; t < 11; t++) begin
            wait_done(5'(t));
        end

        // every slot waits on tag 27
        set_known(5'd27);
        for (int k = 0; k < `IQ_ENTRIES; k++) begin
            dispatch(iq_ctrl_pkg::alu_op_e'(k[1:0]), make_opnd(1'b0, 5'd27),
                     make_opnd(1'b1, '0), 5'(11 + k));
        end
        wait_full(1'b1);
        broadcast(1, 5'd27);
        wait_full(1'b0);
        for (int t = 11; t < 11 + `IQ_ENTRIES; t++) begin
            wait_done(5'(t));
        end

        // flush with work pending and two ops in flight
        // tag 29 sits in the issue register and tag 30 is granted in the flush cycle
        set_known(5'd28);
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b0, 5'd28), make_opnd(1'b1, '0), 5'd19);
        dispatch(iq_ctrl_pkg::OP_SUB, make_opnd(1'b1, '0), make_opnd(1'b0, 5'd28), 5'd20);
        dispatch(iq_ctrl_pkg::OP_AND, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd29);
        dispatch(iq_ctrl_pkg::OP_XOR, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd30);
        flush_with_dispatch(5'd21);
        // the late broadcast must wake nothing
        broadcast(0, 5'd28);
        idle(10);
        dispatch(iq_ctrl_pkg::OP_XOR, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd22);
        dispatch(iq_ctrl_pkg::OP_ADD, make_opnd(1'b1, '0), make_opnd(1'b1, '0), 5'd23);
        wait_done(5'd22);
        wait_done(5'd23);

        idle(5);
        if (u_issue_queue.u_chk.err_cnt != 0) begin
            abort_run("a bound assertion failed during the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: tb/issue_queue_chk.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module issue_queue_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush_i,
    input logic                   full_i,
    input logic [`IQ_ENTRIES-1:0] grant_i,
    input iq_data_pkg::result_t   res_i
);

    // failures so far, polled by the testbench
    int unsigned err_cnt = 0;

    // ------------------------------
    // result stream
    // ------------------------------

    // value has to match the scoreboard entry of its tag
    a_res_value: assert property (@(posedge clk) disable iff (!rst_n)
        res_i.valid |-> (res_i.value == tb_issue_queue.tag_val[res_i.tag]))
    else begin
        err_cnt++;
        $error("MISMATCH res_o.value tag %h got %h exp %h", res_i.tag, res_i.value,
               tb_issue_queue.tag_val[res_i.tag]);
    end

    // only tags still in flight may come back, and only once
    a_res_expected: assert property (@(posedge clk) disable iff (!rst_n)
        res_i.valid |-> tb_issue_queue.outstanding[res_i.tag])
    else begin
        err_cnt++;
        $error("result for tag %h without an outstanding instruction", res_i.tag);
    end

    // ------------------------------
    // flush and occupancy
    // ------------------------------

    // flush empties the issue register and the ALU output
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(flush_i) || $past(flush_i, 2)) |-> !res_i.valid)
    else begin
        err_cnt++;
        $error("result valid within two cycles after a flush");
    end

    // a full queue drains only by a grant or a flush
    a_full_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(full_i) |-> ($past(|grant_i) || $past(flush_i)))
    else begin
        err_cnt++;
        $error("full flag dropped with no grant or flush before it");
    end

endmodule

// File: source/issue_queue.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module issue_queue (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flush_i,

    // dispatch side
    input  logic                                  disp_valid_i,
    input  iq_data_pkg::operand_t [1:0]           disp_src_i,
    input  iq_ctrl_pkg::decode_info_t             disp_di_i,
    output logic                                  full_o,

    // broadcasts from the other units
    input  iq_data_pkg::cdb_t [`IQ_CDB_PORTS-1:0] cdb_i,

    output iq_data_pkg::result_t                  res_o
);

    // ------------------------------
    // internal nets
    // ------------------------------

    logic [`IQ_ENTRIES-1:0]                       entry_valid;
    logic [`IQ_ENTRIES-1:0]                       entry_ready;
    logic [`IQ_ENTRIES-1:0]                       write_oh;
    logic [`IQ_ENTRIES-1:0]                       grant_oh;
    iq_data_pkg::operand_t [`IQ_ENTRIES-1:0][1:0] entry_src;
    iq_ctrl_pkg::decode_info_t [`IQ_ENTRIES-1:0]  entry_di;

    logic                                         iss_valid;
    iq_ctrl_pkg::decode_info_t                    iss_di;
    logic [`IQ_DATA_W-1:0]                        iss_a;
    logic [`IQ_DATA_W-1:0]                        iss_b;

    // back-to-back wakeup from our own ALU
    iq_data_pkg::cdb_t                            wkup;

    // ------------------------------
    // allocation
    // ------------------------------

    iq_alloc u_alloc (
        .valid_i      (entry_valid),
        .disp_valid_i (disp_valid_i),
        .write_o      (write_oh),
        .full_o       (full_o)
    );

    // ------------------------------
    // slots
    // ------------------------------

    for (genvar e = 0; e < `IQ_ENTRIES; e++) begin : g_entry
        iq_entry u_entry (
            .clk     (clk),
            .rst_n   (rst_n),
            .flush_i (flush_i),
            .init_i  (write_oh[e]),
            .src_i   (disp_src_i),
            .di_i    (disp_di_i),
            .cdb_i   (cdb_i),
            .wkup_i  (wkup),
            .grant_i (grant_oh[e]),
            .valid_o (entry_valid[e]),
            .ready_o (entry_ready[e]),
            .src_o   (entry_src[e]),
            .di_o    (entry_di[e])
        );
    end

    // ------------------------------
    // select and execute
    // ------------------------------

    iq_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .ready_i     (entry_ready),
        .src_i       (entry_src),
        .di_i        (entry_di),
        .grant_o     (grant_oh),
        .iss_valid_o (iss_valid),
        .iss_di_o    (iss_di),
        .iss_a_o     (iss_a),
        .iss_b_o     (iss_b)
    );

    iq_alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .iss_valid_i (iss_valid),
        .iss_di_i    (iss_di),
        .iss_a_i     (iss_a),
        .iss_b_i     (iss_b),
        .res_o       (res_o),
        .wkup_o      (wkup)
    );

endmodule

// File: source/iq_alu.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,

    input  logic                      iss_valid_i,
    input  iq_ctrl_pkg::decode_info_t iss_di_i,
    input  logic [`IQ_DATA_W-1:0]     iss_a_i,
    input  logic [`IQ_DATA_W-1:0]     iss_b_i,

    output iq_data_pkg::result_t      res_o,
    output iq_data_pkg::cdb_t         wkup_o
);

    logic [`IQ_DATA_W-1:0] alu_out;
    logic                  res_valid_q;
    logic [`IQ_TAG_W-1:0]  res_tag_q;
    logic [`IQ_DATA_W-1:0] res_value_q;

    // ------------------------------
    // execute
    // ------------------------------

    always_comb begin
        case (iss_di_i.op)
            iq_ctrl_pkg::OP_ADD: alu_out = iss_a_i + iss_b_i;
            iq_ctrl_pkg::OP_SUB: alu_out = iss_a_i - iss_b_i;
            iq_ctrl_pkg::OP_AND: alu_out = iss_a_i & iss_b_i;
            iq_ctrl_pkg::OP_XOR: alu_out = iss_a_i ^ iss_b_i;
            default:             alu_out = '0;
        endcase
    end

    // output register, valid dropped on flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= iss_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i) begin
            res_tag_q   <= iss_di_i.dst_tag;
            res_value_q <= alu_out;
        end
    end

    // result and wakeup carry the same tag and value
    assign res_o.valid  = res_valid_q;
    assign res_o.tag    = res_tag_q;
    assign res_o.value  = res_value_q;
    assign wkup_o.valid = res_valid_q;
    assign wkup_o.tag   = res_tag_q;
    assign wkup_o.value = res_value_q;

endmodule

// File: source/iq_select.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_select (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        flush_i,

    // per-slot request and contents
    input  logic [`IQ_ENTRIES-1:0]                      ready_i,
    input  iq_data_pkg::operand_t [`IQ_ENTRIES-1:0][1:0] src_i,
    input  iq_ctrl_pkg::decode_info_t [`IQ_ENTRIES-1:0] di_i,

    output logic [`IQ_ENTRIES-1:0]                      grant_o,

    // issue register into the ALU
    output logic                                        iss_valid_o,
    output iq_ctrl_pkg::decode_info_t                   iss_di_o,
    output logic [`IQ_DATA_W-1:0]                       iss_a_o,
    output logic [`IQ_DATA_W-1:0]                       iss_b_o
);

    // ------------------------------
    // fixed priority pick
    // ------------------------------

    logic [`IQ_ENTRIES-1:0]    grant;
    iq_ctrl_pkg::decode_info_t sel_di;
    logic [`IQ_DATA_W-1:0]     sel_a;
    logic [`IQ_DATA_W-1:0]     sel_b;

    // lowest index ready slot
    assign grant   = ready_i & (~ready_i + 1'b1);
    assign grant_o = grant;

    // mux of the granted slot, grant is one-hot
    always_comb begin
        sel_di = '0;
        sel_a  = '0;
        sel_b  = '0;
        for (int k = 0; k < `IQ_ENTRIES; k++) begin
            if (grant[k]) begin
                sel_di = di_i[k];
                sel_a  = src_i[k][0].value;
                sel_b  = src_i[k][1].value;
            end
        end
    end

    // ------------------------------
    // issue register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid_o <= 1'b0;
        end else if (flush_i) begin
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= |ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (|ready_i) begin
            iss_di_o <= sel_di;
            iss_a_o  <= sel_a;
            iss_b_o  <= sel_b;
        end
    end

endmodule

// File: source/iq_alloc.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_alloc (
    // occupancy of every slot
    input  logic [`IQ_ENTRIES-1:0] valid_i,
    input  logic                   disp_valid_i,

    // one-hot write enable into the slots
    output logic [`IQ_ENTRIES-1:0] write_o,
    output logic                   full_o
);

    // ------------------------------
    // free slot search
    // ------------------------------

    logic [`IQ_ENTRIES-1:0] free;
    logic [`IQ_ENTRIES-1:0] first_free;

    assign free = ~valid_i;

    // isolate the lowest set bit
    assign first_free = free & (~free + 1'b1);

    // ------------------------------
    // outputs
    // ------------------------------

    // no write at all without a dispatch strobe
    assign write_o = first_free & {`IQ_ENTRIES{disp_valid_i}};

    // every slot taken
    assign full_o = &valid_i;

endmodule

// File: source/iq_entry.sv
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_entry (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush_i,

    // new instruction written into this slot
    input  logic                                    init_i,
    input  iq_data_pkg::operand_t [1:0]             src_i,
    input  iq_ctrl_pkg::decode_info_t               di_i,

    // broadcast sources watched by pending operands
    input  iq_data_pkg::cdb_t [`IQ_CDB_PORTS-1:0]   cdb_i,
    input  iq_data_pkg::cdb_t                       wkup_i,

    // slot picked for issue this cycle
    input  logic                                    grant_i,

    output logic                                    valid_o,
    output logic                                    ready_o,
    output iq_data_pkg::operand_t [1:0]             src_o,
    output iq_ctrl_pkg::decode_info_t               di_o
);

    // ------------------------------
    // slot storage
    // ------------------------------

    logic                        valid_q;
    iq_data_pkg::operand_t [1:0] opnd_q;
    iq_ctrl_pkg::decode_info_t   di_q;

    // ------------------------------
    // operand capture
    // ------------------------------

    // resolves one operand against the broadcasts of this cycle
    // priority: cdb port 0, higher cdb ports, then the wakeup
    function automatic iq_data_pkg::operand_t capture(
        input iq_data_pkg::operand_t                     op,
        input iq_data_pkg::cdb_t [`IQ_CDB_PORTS-1:0]     cdb,
        input iq_data_pkg::cdb_t                         wkup
    );
        iq_data_pkg::operand_t res;
        logic                  hit;
        res = op;
        hit = 1'b0;
        // only pending operands look at tags
        if (!op.ready) begin
            for (int p = 0; p < `IQ_CDB_PORTS; p++) begin
                if (!hit && cdb[p].valid && (cdb[p].tag == op.tag)) begin
                    res.ready = 1'b1;
                    res.value = cdb[p].value;
                    hit       = 1'b1;
                end
            end
            if (!hit && wkup.valid && (wkup.tag == op.tag)) begin
                res.ready = 1'b1;
                res.value = wkup.value;
            end
        end
        return res;
    endfunction

    // ------------------------------
    // valid bit
    // ------------------------------

    // flush wins over a dispatch in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (init_i) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0;
        end
    end

    // decode info only loaded at dispatch
    always_ff @(posedge clk) begin
        if (init_i) begin
            di_q <= di_i;
        end
    end

    // each operand: initial write with bypass, else watch broadcasts
    for (genvar i = 0; i < 2; i++) begin : g_opnd
        always_ff @(posedge clk) begin
            if (init_i) begin
                opnd_q[i] <= capture(src_i[i], cdb_i, wkup_i);
            end else if (valid_q) begin
                opnd_q[i] <= capture(opnd_q[i], cdb_i, wkup_i);
            end
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------

    assign valid_o = valid_q;
    assign ready_o = valid_q & opnd_q[0].ready & opnd_q[1].ready;
    assign src_o   = opnd_q;
    assign di_o    = di_q;

endmodule

// File: source/iq_ctrl_pkg.sv
`include "iq_params.svh"

package iq_ctrl_pkg;

    // ------------------------------
    // ALU opcodes
    // ------------------------------

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_e;

    // ------------------------------
    // static part of a slot
    // ------------------------------

    // written once at dispatch, never updated afterwards
    typedef struct packed {
        alu_op_e              op;
        logic [`IQ_TAG_W-1:0] dst_tag;
    } decode_info_t;

endpackage

// File: source/iq_data_pkg.sv
`include "iq_params.svh"

package iq_data_pkg;

    // ------------------------------
    // operand as held in a slot
    // ------------------------------

    // value only meaningful once ready is set
    typedef struct packed {
        logic                 ready;
        logic [`IQ_TAG_W-1:0]  tag;
        logic [`IQ_DATA_W-1:0] value;
    } operand_t;

    // ------------------------------
    // broadcast and result buses
    // ------------------------------

    // shared by the CDB ports and the back-to-back wakeup
    typedef struct packed {
        logic                 valid;
        logic [`IQ_TAG_W-1:0]  tag;
        logic [`IQ_DATA_W-1:0] value;
    } cdb_t;

    // tag is the destination register of the issued op
    typedef struct packed {
        logic                 valid;
        logic [`IQ_TAG_W-1:0]  tag;
        logic [`IQ_DATA_W-1:0] value;
    } result_t;

endpackage

// File: source/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// ------------------------------
// queue geometry
// ------------------------------

// number of slots in the queue
`define IQ_ENTRIES 8

// physical register tag width
`define IQ_TAG_W 5

// operand and result width
`define IQ_DATA_W 32

// broadcast ports driven by the other units
`define IQ_CDB_PORTS 2

`endif
